//--- rtl/isa_pkg.sv
package isa_pkg;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_t;

	// ALU funct3 shared by register and immediate forms
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101; // srl or sra by bit 30
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [2:0] f3_double = 3'b011; // ld / sd

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_slt    = 4'd5,
		alu_sltu   = 4'd6,
		alu_sll    = 4'd7,
		alu_srl    = 4'd8,
		alu_sra    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_t;

	typedef enum logic [2:0] {
		br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
	} branch_t;

	typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_t;

	localparam logic [31:0] nop_instr = 32'h0000_0013; // addi x0,x0,0

endpackage

//--- rtl/pipe_pkg.sv
package pipe_pkg;

	typedef logic [63:0] u64;
	typedef logic [31:0] u32;
	typedef logic [4:0] reg_addr_t;

	localparam u64 reset_pc = 64'h0000_0000_8000_0000;

	// Forwarding selects into execute
	localparam logic [1:0] fwd_none = 2'd0;
	localparam logic [1:0] fwd_mem  = 2'd1;
	localparam logic [1:0] fwd_wb   = 2'd2;

	typedef struct packed {
		logic valid;
		u64   addr;
	} ibus_req_t;

	typedef struct packed {
		logic data_ok;
		u32   data;
	} ibus_resp_t;

	typedef struct packed {
		logic valid;
		logic write;
		u64   addr;
		u64   wdata;
	} dbus_req_t;

	typedef struct packed {
		logic data_ok;
		u64   rdata;
	} dbus_resp_t;

	typedef struct packed {
		isa_pkg::alu_op_t alu_op;
		logic             alu_src_imm; // operand b from imm
		logic             src_a_pc;    // operand a from pc
		isa_pkg::branch_t branch;
		logic             mem_read;
		logic             mem_write;
		logic             reg_write;
		logic             link;        // write pc+4
	} ctl_t;

	typedef struct packed {
		logic valid;
		u64   pc;
		u32   raw_instr;
	} fetch_data_t;

	// Empty if_id slot decodes as a harmless nop
	localparam fetch_data_t fetch_bubble = '{
		valid: 1'b0, pc: '0, raw_instr: isa_pkg::nop_instr
	};

	typedef struct packed {
		logic      valid;
		u64        pc;
		ctl_t      ctl;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t dst;
		u64        imm;
		u64        rd1;
		u64        rd2;
	} decode_data_t;

	typedef struct packed {
		logic      valid;
		u64        pc;
		ctl_t      ctl;
		reg_addr_t dst;
		u64        result;
		u64        store_data;
	} execute_data_t;

	typedef struct packed {
		logic      valid;
		ctl_t      ctl;
		reg_addr_t dst;
		u64        wb_data;
	} memory_data_t;

endpackage

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  pipe_pkg::u32        raw_instr,
	output pipe_pkg::ctl_t      ctl,
	output pipe_pkg::reg_addr_t rs1,
	output pipe_pkg::reg_addr_t rs2,
	output pipe_pkg::reg_addr_t dst,
	output pipe_pkg::u64        imm,
	output logic                uses_rs1,
	output logic                uses_rs2
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t opcode;
	logic [2:0] funct3;
	imm_t fmt;

	function automatic alu_op_t alu_from_funct(logic [2:0] f3, logic alt, logic reg_form);
		alu_op_t op;
		op = alu_add;
		case (f3)
			f3_add:  op = (alt && reg_form) ? alu_sub : alu_add; // no subi
			f3_sll:  op = alu_sll;
			f3_slt:  op = alu_slt;
			f3_sltu: op = alu_sltu;
			f3_xor:  op = alu_xor;
			f3_sr:   op = alt ? alu_sra : alu_srl;
			f3_or:   op = alu_or;
			f3_and:  op = alu_and;
		endcase
		return op;
	endfunction

	function automatic branch_t branch_from_funct(logic [2:0] f3);
		case (f3)
			f3_beq:  return br_eq;
			f3_bne:  return br_ne;
			f3_blt:  return br_lt;
			f3_bge:  return br_ge;
			f3_bltu: return br_ltu;
			f3_bgeu: return br_geu;
			default: return br_none;
		endcase
	endfunction

	assign opcode = opcode_t'(raw_instr[6:0]);
	assign funct3 = raw_instr[14:12];
	assign rs1 = raw_instr[19:15];
	assign rs2 = raw_instr[24:20];
	assign dst = raw_instr[11:7];

	always_comb begin
		ctl = '0;
		fmt = imm_i;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			op_lui: begin
				ctl.alu_op = alu_pass_b;
				ctl.alu_src_imm = 1'b1;
				ctl.reg_write = 1'b1;
				fmt = imm_u;
			end
			op_auipc: begin
				ctl.src_a_pc = 1'b1;
				ctl.alu_src_imm = 1'b1;
				ctl.reg_write = 1'b1;
				fmt = imm_u;
			end
			op_jal: begin
				ctl.branch = br_jump;
				ctl.src_a_pc = 1'b1;
				ctl.reg_write = 1'b1;
				ctl.link = 1'b1;
				fmt = imm_j;
			end
			op_jalr: begin
				ctl.branch = br_jump;
				ctl.reg_write = 1'b1;
				ctl.link = 1'b1;
				uses_rs1 = 1'b1;
			end
			op_branch: begin
				ctl.branch = branch_from_funct(funct3);
				ctl.src_a_pc = 1'b1; // target base
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				fmt = imm_b;
			end
			op_load: if (funct3 == f3_double) begin
				ctl.alu_src_imm = 1'b1;
				ctl.mem_read = 1'b1;
				ctl.reg_write = 1'b1;
				uses_rs1 = 1'b1;
			end
			op_store: if (funct3 == f3_double) begin
				ctl.alu_src_imm = 1'b1;
				ctl.mem_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				fmt = imm_s;
			end
			op_imm: begin
				ctl.alu_op = alu_from_funct(funct3, raw_instr[30], 1'b0);
				ctl.alu_src_imm = 1'b1;
				ctl.reg_write = 1'b1;
				uses_rs1 = 1'b1;
			end
			op_reg: begin
				ctl.alu_op = alu_from_funct(funct3, raw_instr[30], 1'b1);
				ctl.reg_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (fmt)
			imm_s:   imm = {{52{raw_instr[31]}}, raw_instr[31:25], raw_instr[11:7]};
			imm_b:   imm = {{52{raw_instr[31]}}, raw_instr[7], raw_instr[30:25],
				raw_instr[11:8], 1'b0};
			imm_u:   imm = {{32{raw_instr[31]}}, raw_instr[31:12], 12'b0};
			imm_j:   imm = {{44{raw_instr[31]}}, raw_instr[19:12], raw_instr[20],
				raw_instr[30:21], 1'b0};
			default: imm = {{52{raw_instr[31]}}, raw_instr[31:20]};
		endcase
	end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic                clk,
	input  logic                rst,
	input  pipe_pkg::reg_addr_t ra1,
	input  pipe_pkg::reg_addr_t ra2,
	output pipe_pkg::u64        rd1,
	output pipe_pkg::u64        rd2,
	input  logic                we,
	input  pipe_pkg::reg_addr_t wa,
	input  pipe_pkg::u64        wd
);
	import pipe_pkg::*;

	u64 regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Writeback value bypasses to decode in the same cycle
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input  pipe_pkg::reg_addr_t id_rs1,
	input  pipe_pkg::reg_addr_t id_rs2,
	input  logic                id_uses_rs1,
	input  logic                id_uses_rs2,
	input  pipe_pkg::reg_addr_t ex_rs1,
	input  pipe_pkg::reg_addr_t ex_rs2,
	input  logic                ex_load,
	input  pipe_pkg::reg_addr_t ex_dst,
	input  pipe_pkg::reg_addr_t mem_dst,
	input  logic                mem_reg_write, // loads excluded by caller
	input  pipe_pkg::reg_addr_t wb_dst,
	input  logic                wb_reg_write,
	output logic [1:0]          fwd_a,
	output logic [1:0]          fwd_b,
	output logic                load_stall
);
	import pipe_pkg::*;

	function automatic logic [1:0] fwd_sel(reg_addr_t src);
		if (src == '0)
			return fwd_none;
		if (mem_reg_write && mem_dst == src)
			return fwd_mem; // younger result wins
		if (wb_reg_write && wb_dst == src)
			return fwd_wb;
		return fwd_none;
	endfunction

	always_comb begin
		fwd_a = fwd_sel(ex_rs1);
		fwd_b = fwd_sel(ex_rs2);
	end

	// Load in execute feeding the instruction in decode
	assign load_stall = ex_load && ex_dst != '0 &&
		((id_uses_rs1 && id_rs1 == ex_dst) || (id_uses_rs2 && id_rs2 == ex_dst));

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input  pipe_pkg::decode_data_t  data,
	input  logic [1:0]              fwd_a,
	input  logic [1:0]              fwd_b,
	input  pipe_pkg::u64            mem_value,
	input  pipe_pkg::u64            wb_value,
	output pipe_pkg::execute_data_t result,
	output logic                    taken,
	output pipe_pkg::u64            target
);
	import isa_pkg::*;
	import pipe_pkg::*;

	u64 src_a, src_b;
	u64 op_a, op_b;
	u64 alu_out;
	logic eq, lt, ltu;
	logic cond;

	function automatic u64 operand(logic [1:0] sel, u64 reg_value);
		case (sel)
			fwd_mem: return mem_value;
			fwd_wb:  return wb_value;
			default: return reg_value;
		endcase
	endfunction

	always_comb begin
		src_a = operand(fwd_a, data.rd1);
		src_b = operand(fwd_b, data.rd2);
	end

	assign op_a = data.ctl.src_a_pc ? data.pc : src_a;
	assign op_b = data.ctl.alu_src_imm ? data.imm : src_b;

	always_comb begin
		case (data.ctl.alu_op)
			alu_add:    alu_out = op_a + op_b;
			alu_sub:    alu_out = op_a - op_b;
			alu_and:    alu_out = op_a & op_b;
			alu_or:     alu_out = op_a | op_b;
			alu_xor:    alu_out = op_a ^ op_b;
			alu_slt:    alu_out = {63'b0, $signed(op_a) < $signed(op_b)};
			alu_sltu:   alu_out = {63'b0, op_a < op_b};
			alu_sll:    alu_out = op_a << op_b[5:0];
			alu_srl:    alu_out = op_a >> op_b[5:0];
			alu_sra:    alu_out = $signed(op_a) >>> op_b[5:0];
			alu_pass_b: alu_out = op_b;
			default:    alu_out = '0;
		endcase
	end

	// Branch compare uses register operands, never the immediate
	assign eq = src_a == src_b;
	assign lt = $signed(src_a) < $signed(src_b);
	assign ltu = src_a < src_b;

	always_comb begin
		case (data.ctl.branch)
			br_eq:   cond = eq;
			br_ne:   cond = ~eq;
			br_lt:   cond = lt;
			br_ge:   cond = ~lt;
			br_ltu:  cond = ltu;
			br_geu:  cond = ~ltu;
			br_jump: cond = 1'b1;
			default: cond = 1'b0;
		endcase
	end

	assign taken = data.valid & cond;
	assign target = (op_a + data.imm) & ~64'd1; // pc or rs1 base

	always_comb begin
		result.valid = data.valid;
		result.pc = data.pc;
		result.ctl = data.ctl;
		result.dst = data.dst;
		result.result = data.ctl.link ? data.pc + 64'd4 : alu_out;
		result.store_data = src_b;
	end

endmodule

//--- rtl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic,
	parameter payload_t empty = '0
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     hold,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk) begin
		if (rst) begin
			q <= empty;
		end else if (!hold) begin // hold beats flush
			if (flush)
				q <= empty;
			else
				q <= d;
		end
	end

endmodule

//--- rtl/core.sv
`timescale 1ns/1ps

module core (
	input  logic                 clk,
	input  logic                 rst,
	output pipe_pkg::ibus_req_t  ireq,
	input  pipe_pkg::ibus_resp_t iresp,
	output pipe_pkg::dbus_req_t  dreq,
	input  pipe_pkg::dbus_resp_t dresp
);
	import pipe_pkg::*;

	u64 pc, pc_next;
	logic fetch_on;
	logic fetch_ok;
	logic stall_mem, load_stall;
	logic taken;
	u64 target;

	fetch_data_t if_d, if_q;
	decode_data_t id_d, id_q;
	execute_data_t ex_d, ex_q;
	memory_data_t mem_d, mem_q;

	ctl_t dec_ctl;
	reg_addr_t dec_rs1, dec_rs2, dec_dst;
	u64 dec_imm;
	logic uses_rs1, uses_rs2;
	u64 rd1, rd2;
	logic [1:0] fwd_a, fwd_b;

	// Fetch
	assign ireq.valid = fetch_on;
	assign ireq.addr = pc;
	assign fetch_ok = fetch_on & iresp.data_ok;

	always_comb begin
		if_d = fetch_bubble;
		if_d.pc = pc;
		if (fetch_ok) begin
			if_d.valid = 1'b1;
			if_d.raw_instr = iresp.data;
		end
	end

	always_comb begin
		if (stall_mem)
			pc_next = pc;
		else if (taken)
			pc_next = target;
		else if (load_stall || !fetch_ok)
			pc_next = pc; // refetch
		else
			pc_next = pc + 64'd4;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
			fetch_on <= 1'b0;
		end else begin
			pc <= pc_next;
			fetch_on <= 1'b1;
		end
	end

	stage_reg #(.payload_t(fetch_data_t), .empty(fetch_bubble)) if_id (
		.clk, .rst,
		.hold(stall_mem | load_stall),
		.flush(taken),
		.d(if_d),
		.q(if_q)
	);

	// Decode
	decoder decoder (
		.raw_instr(if_q.raw_instr),
		.ctl(dec_ctl),
		.rs1(dec_rs1),
		.rs2(dec_rs2),
		.dst(dec_dst),
		.imm(dec_imm),
		.uses_rs1,
		.uses_rs2
	);

	regfile regfile (
		.clk, .rst,
		.ra1(dec_rs1),
		.ra2(dec_rs2),
		.rd1,
		.rd2,
		.we(mem_q.ctl.reg_write),
		.wa(mem_q.dst),
		.wd(mem_q.wb_data)
	);

	hazard_unit hazard_unit (
		.id_rs1(dec_rs1),
		.id_rs2(dec_rs2),
		.id_uses_rs1(uses_rs1 & if_q.valid),
		.id_uses_rs2(uses_rs2 & if_q.valid),
		.ex_rs1(id_q.rs1),
		.ex_rs2(id_q.rs2),
		.ex_load(id_q.ctl.mem_read),
		.ex_dst(id_q.dst),
		.mem_dst(ex_q.dst),
		.mem_reg_write(ex_q.ctl.reg_write & ~ex_q.ctl.mem_read),
		.wb_dst(mem_q.dst),
		.wb_reg_write(mem_q.ctl.reg_write),
		.fwd_a,
		.fwd_b,
		.load_stall
	);

	always_comb begin
		id_d.valid = if_q.valid;
		id_d.pc = if_q.pc;
		id_d.ctl = if_q.valid ? dec_ctl : '0; // bubbles carry no control
		id_d.rs1 = dec_rs1;
		id_d.rs2 = dec_rs2;
		id_d.dst = dec_dst;
		id_d.imm = dec_imm;
		id_d.rd1 = rd1;
		id_d.rd2 = rd2;
	end

	stage_reg #(.payload_t(decode_data_t)) id_ex (
		.clk, .rst,
		.hold(stall_mem),
		.flush(taken | load_stall),
		.d(id_d),
		.q(id_q)
	);

	// Execute
	exec_unit exec_unit (
		.data(id_q),
		.fwd_a,
		.fwd_b,
		.mem_value(ex_q.result),
		.wb_value(mem_q.wb_data),
		.result(ex_d),
		.taken,
		.target
	);

	stage_reg #(.payload_t(execute_data_t)) ex_mem (
		.clk, .rst,
		.hold(stall_mem),
		.flush(1'b0),
		.d(ex_d),
		.q(ex_q)
	);

	// Memory
	assign dreq.valid = ex_q.ctl.mem_read | ex_q.ctl.mem_write;
	assign dreq.write = ex_q.ctl.mem_write;
	assign dreq.addr = ex_q.result;
	assign dreq.wdata = ex_q.store_data;
	assign stall_mem = dreq.valid & ~dresp.data_ok;

	always_comb begin
		mem_d.valid = ex_q.valid;
		mem_d.ctl = ex_q.ctl;
		mem_d.dst = ex_q.dst;
		mem_d.wb_data = ex_q.ctl.mem_read ? dresp.rdata : ex_q.result;
	end

	stage_reg #(.payload_t(memory_data_t)) mem_wb (
		.clk, .rst,
		.hold(stall_mem),
		.flush(1'b0),
		.d(mem_d),
		.q(mem_q)
	);

endmodule

//--- testbench/tb_mem.sv
`timescale 1ns/1ps

module tb_mem (
	input  logic                 clk,
	input  logic                 rst,
	input  pipe_pkg::ibus_req_t  ireq,
	output pipe_pkg::ibus_resp_t iresp,
	input  pipe_pkg::dbus_req_t  dreq,
	output pipe_pkg::dbus_resp_t dresp,
	output int                   prog_len
);
	import pipe_pkg::*;

	logic [31:0] rom [128];
	u64 ram [256];
	int pos;
	int seed;
	int wait_left;
	logic pending;

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23}; // sd
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] off, logic [2:0] f3, logic [4:0] rs1,
		logic [4:0] rs2);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [31:0] fetch_word(u64 addr);
		u64 off;
		off = addr - reset_pc;
		if (off < 64'd512)
			return rom[off[8:2]];
		return 32'h0000_0013;
	endfunction

	task automatic put(logic [31:0] w);
		rom[pos] = w;
		pos++;
	endtask

	// Store to 0x1f8 only reachable on a wrong path
	task automatic bad_store();
		put(enc_s(12'h0f8, 5'd8, 5'd1));
	endtask

	task automatic branch_taken(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
		put(enc_b(13'd8, f3, rs1, rs2));
		bad_store();
	endtask

	task automatic branch_not_taken(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
		put(enc_b(13'd8, f3, rs1, rs2));
		put(enc_j(21'd8, 5'd0)); // skip over the bad store
		bad_store();
	endtask

	initial begin
		for (int i = 0; i < 128; i++)
			rom[i] = 32'h0000_0013;
		for (int i = 0; i < 256; i++)
			ram[i] = {32'h600d_0000 | i, 32'hf00d_0000 | i};
		pos = 0;
		put(enc_i(12'h100, 5'd0, 3'd0, 5'd1, 7'h13));  // x1 = signature base
		put(enc_i(12'd7, 5'd0, 3'd0, 5'd2, 7'h13));
		put(enc_i(12'd5, 5'd2, 3'd0, 5'd3, 7'h13));
		put(enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd4));
		put(enc_r(7'h20, 5'd2, 5'd4, 3'd0, 5'd5));    // sub
		put(enc_s(12'd0, 5'd5, 5'd1));
		put(enc_s(12'd8, 5'd4, 5'd1));
		put(enc_u(20'h12345, 5'd6, 7'h37));
		put(enc_i(12'h678, 5'd6, 3'd0, 5'd6, 7'h13));
		put(enc_s(12'd16, 5'd6, 5'd1));
		put(enc_u(20'h00001, 5'd7, 7'h17));           // auipc at 0x80000028
		put(enc_s(12'd24, 5'd7, 5'd1));
		put(enc_i(12'hfff, 5'd0, 3'd0, 5'd8, 7'h13));
		put(enc_i(12'd60, 5'd8, 3'd5, 5'd9, 7'h13));   // srli
		put(enc_i(12'd8, 5'd9, 3'd1, 5'd10, 7'h13));   // slli
		put(enc_r(7'h00, 5'd8, 5'd10, 3'd4, 5'd11));  // xor
		put(enc_i(12'h404, 5'd11, 3'd5, 5'd12, 7'h13)); // srai
		put(enc_s(12'd32, 5'd12, 5'd1));
		put(enc_r(7'h00, 5'd2, 5'd8, 3'd2, 5'd13));   // slt
		put(enc_r(7'h00, 5'd8, 5'd2, 3'd3, 5'd14));   // sltu
		put(enc_i(12'd1, 5'd14, 3'd1, 5'd14, 7'h13));
		put(enc_r(7'h00, 5'd14, 5'd13, 3'd6, 5'd15));
		put(enc_r(7'h00, 5'd10, 5'd15, 3'd6, 5'd15));
		put(enc_r(7'h00, 5'd11, 5'd15, 3'd7, 5'd16));
		put(enc_s(12'd40, 5'd15, 5'd1));
		put(enc_s(12'd48, 5'd16, 5'd1));
		put(enc_r(7'h20, 5'd2, 5'd11, 3'd5, 5'd17));  // sra
		put(enc_r(7'h00, 5'd2, 5'd10, 3'd5, 5'd18));  // srl
		put(enc_s(12'd56, 5'd17, 5'd1));
		put(enc_s(12'd64, 5'd18, 5'd1));
		put(enc_i(12'h300, 5'd1, 3'd3, 5'd19, 7'h03)); // ld from 0x400
		put(enc_i(12'd5, 5'd19, 3'd0, 5'd20, 7'h13));
		put(enc_s(12'd72, 5'd20, 5'd1));
		put(enc_i(12'h308, 5'd1, 3'd3, 5'd21, 7'h03));
		put(enc_s(12'd80, 5'd21, 5'd1));
		branch_taken(3'd0, 5'd13, 5'd13);
		branch_not_taken(3'd0, 5'd2, 5'd13);
		branch_taken(3'd1, 5'd2, 5'd13);
		branch_not_taken(3'd1, 5'd2, 5'd2);
		branch_taken(3'd4, 5'd8, 5'd2);
		branch_not_taken(3'd4, 5'd2, 5'd8);
		branch_taken(3'd5, 5'd2, 5'd8);
		branch_not_taken(3'd5, 5'd8, 5'd2);
		branch_taken(3'd6, 5'd2, 5'd8);
		branch_not_taken(3'd6, 5'd8, 5'd2);
		branch_taken(3'd7, 5'd8, 5'd2);
		branch_not_taken(3'd7, 5'd2, 5'd8);
		put(enc_j(21'd8, 5'd23));                     // jal at 0x80000104
		bad_store();
		put(enc_s(12'd88, 5'd23, 5'd1));
		put(enc_u(20'h00000, 5'd24, 7'h17));
		put(enc_i(12'd13, 5'd24, 3'd0, 5'd25, 7'h67)); // odd target loses bit 0
		bad_store();
		put(enc_s(12'd96, 5'd25, 5'd1));
		put(enc_i(12'd0, 5'd1, 3'd3, 5'd26, 7'h03));
		put(enc_r(7'h00, 5'd26, 5'd26, 3'd0, 5'd27));
		put(enc_s(12'd104, 5'd27, 5'd1));
		put(enc_s(12'd112, 5'd26, 5'd1));
		put(enc_j(21'd0, 5'd0));                      // spin here
		prog_len = pos;
	end

	initial begin
		seed = 32'h604f;
		iresp = '0;
		dresp = '0;
		pending = 1'b0;
		wait_left = 0;
	end

	always @(negedge clk) begin
		if (rst) begin
			iresp = '0;
			dresp = '0;
			pending = 1'b0;
		end else begin
			iresp.data_ok = ireq.valid;
			iresp.data = fetch_word(ireq.addr);
			dresp = '0;
			if (dreq.valid) begin
				if (!pending) begin
					wait_left = $random(seed) & 32'd3;
					pending = 1'b1;
				end
				if (wait_left == 0) begin
					pending = 1'b0;
					dresp.data_ok = 1'b1;
					if (dreq.write)
						ram[dreq.addr[10:3]] = dreq.wdata;
					else
						dresp.rdata = ram[dreq.addr[10:3]];
				end else begin
					wait_left--;
				end
			end
		end
	end

endmodule

//--- testbench/tb_core.sv
`timescale 1ns/1ps

module tb_core;
	import pipe_pkg::*;

	localparam int n_tests = 5;
	localparam int drain_cycles = 20; // room for stray wrong-path stores

	logic clk;
	logic rst;
	ibus_req_t ireq;
	ibus_resp_t iresp;
	dbus_req_t dreq;
	dbus_resp_t dresp;
	int prog_len;

	u64 exp_addr [$];
	u64 exp_data [$];
	int exp_test [$];
	int errs [1:n_tests];
	string names [1:n_tests];
	int stores_seen;
	int cycles;
	logic reset_applied;
	logic fetch_seen;
	logic waiting;
	dbus_req_t last_req;
	int total;
	int passed;

	core dut (.clk, .rst, .ireq, .iresp, .dreq, .dresp);

	tb_mem mem (.clk, .rst, .ireq, .iresp, .dreq, .dresp, .prog_len);

	task automatic expect_store(int t, u64 addr, u64 data);
		exp_test.push_back(t);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic report_test(int t);
		$display("test %0d %s: %s", t, names[t], errs[t] == 0 ? "ok" : "FAILED");
	endtask

	task automatic check_store();
		int i;
		int t;
		i = stores_seen;
		if (i >= exp_addr.size()) begin
			$display("Unexpected extra store to %h at %0t", dreq.addr, $time);
			errs[n_tests]++;
		end else begin
			t = exp_test[i];
			assert (dreq.addr == exp_addr[i]) else begin
				$display("MISMATCH time=%0t dreq.addr expected=%h actual=%h",
					$time, exp_addr[i], dreq.addr);
				errs[t]++;
			end
			assert (dreq.wdata == exp_data[i]) else begin
				$display("MISMATCH time=%0t dreq.wdata expected=%h actual=%h",
					$time, exp_data[i], dreq.wdata);
				errs[t]++;
			end
			if (t != n_tests && (i + 1 == exp_addr.size() || exp_test[i + 1] != t))
				report_test(t);
		end
		stores_seen++;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (prog_len > 0 && cycles >= 40 * prog_len) begin
			$display("Timeout after %0d cycles, %0d of %0d stores seen",
				cycles, stores_seen, exp_addr.size());
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Bus monitor sampled on the rising edge
	always @(posedge clk) begin
		if (rst) begin
			// Synchronous reset takes hold at the first edge
			if (reset_applied) begin
				assert (!dreq.valid && !ireq.valid) else begin
					$display("Bus request active during reset at %0t", $time);
					errs[1]++;
				end
			end
			reset_applied = 1'b1;
		end else begin
			if (!fetch_seen) begin
				assert (!dreq.valid) else begin
					$display("Data request before the first fetch at %0t", $time);
					errs[1]++;
				end
				if (ireq.valid) begin
					assert (ireq.addr == reset_pc) else begin
						$display("MISMATCH time=%0t ireq.addr expected=%h actual=%h",
							$time, reset_pc, ireq.addr);
						errs[1]++;
					end
					fetch_seen = 1'b1;
					report_test(1);
				end
			end
			if (waiting) begin
				assert (dreq == last_req) else begin
					$display("dreq changed while waiting for data_ok at %0t", $time);
					errs[n_tests]++;
				end
			end
			waiting = dreq.valid && !dresp.data_ok;
			last_req = dreq;
			if (dreq.valid && dreq.write && dresp.data_ok)
				check_store();
		end
	end

	initial begin
		rst = 1'b1;
		stores_seen = 0;
		cycles = 0;
		reset_applied = 1'b0;
		fetch_seen = 1'b0;
		waiting = 1'b0;
		last_req = '0;
		for (int t = 1; t <= n_tests; t++)
			errs[t] = 0;
		names[1] = "reset state";
		names[2] = "alu forwarding";
		names[3] = "load-use stall";
		names[4] = "branches and jumps";
		names[5] = "data bus latency";

		// Signature base is 0x100
		expect_store(2, 64'h100, 64'd7 + 64'd5);
		expect_store(2, 64'h108, 64'd7 + 64'd12);
		expect_store(2, 64'h110, 64'h1234_5678);
		expect_store(2, 64'h118, 64'h8000_0028 + 64'h1000);
		expect_store(2, 64'h120, 64'hffff_ffff_ffff_ff0f);
		expect_store(2, 64'h128, 64'hf03);
		expect_store(2, 64'h130, 64'h3);
		expect_store(2, 64'h138, 64'hffff_ffff_ffff_ffe1); // -3841 >>> 7
		expect_store(2, 64'h140, 64'h1e);
		expect_store(3, 64'h148, 64'h600d_0080_f00d_0080 + 64'd5);
		expect_store(3, 64'h150, 64'h600d_0081_f00d_0081);
		expect_store(4, 64'h158, 64'h8000_0108);
		expect_store(4, 64'h160, 64'h8000_0118);
		expect_store(5, 64'h168, 64'd24);
		expect_store(5, 64'h170, 64'd12);

		repeat (4) @(negedge clk);
		rst = 1'b0;

		wait (stores_seen == exp_addr.size());
		repeat (drain_cycles) @(posedge clk);
		report_test(n_tests);

		total = 0;
		passed = 0;
		for (int t = 1; t <= n_tests; t++) begin
			total += errs[t];
			if (errs[t] == 0)
				passed++;
		end
		$display("tests passed: %0d of %0d, errors: %0d", passed, n_tests, total);
		if (total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- sources.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/hazard_unit.sv
rtl/exec_unit.sv
rtl/stage_reg.sv
rtl/core.sv
testbench/tb_mem.sv
testbench/tb_core.sv

//--- Makefile
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: obj_dir/Vtb_core

obj_dir/Vtb_core: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_core -f sources.f -o Vtb_core

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
